// ==== compile.f ====
+incdir+.
pc_bus_pkg.sv
pc_map_pkg.sv
stream_stage.sv
port_decoder.sv
mem_decoder.sv
board_registers.sv
pc_bus_glue.sv
tb_pc_bus_glue.sv

// ==== pc_bus_cases.txt ====
# name kind addr wdata target unit chan page nmi
# hex values, kind and target in the package encodings
io_rd_dma   2 00000 00 1 0 0 0 0
io_wr_dma   3 00010 5a 1 0 0 0 0
io_rd_int   2 00020 00 2 0 0 0 0
io_wr_int   3 00021 13 2 0 0 0 0
io_rd_timer 2 00040 00 3 0 0 0 0
io_wr_timer 3 00043 36 3 0 0 0 0
io_rd_ppi   2 00060 00 4 0 0 0 0
io_wr_ppi   3 00061 4c 4 0 0 0 0
io_rd_page  2 00080 00 0 0 0 0 0
io_rd_nmi   2 000a0 00 0 0 0 0 0
io_rd_g6    2 000c0 00 0 0 0 0 0
io_wr_g6    3 000c0 ff 0 0 0 0 0
io_rd_g7    2 000e0 00 0 0 0 0 0
io_wr_g7    3 000ff 00 0 0 0 0 0
io_bit8     2 00100 00 0 0 0 0 0
io_bit9     3 00221 00 0 0 0 0 0
io_alias_rd 2 fc040 00 3 0 0 0 0
io_alias_wr 3 12c61 00 4 0 0 0 0
ram_b0      0 00000 00 8 0 0 0 0
ram_b1      1 1abcd 3c 8 1 0 0 0
ram_b2      0 2ffff 00 8 2 0 0 0
ram_b3      1 30000 00 8 3 0 0 0
rom_c2      0 f4000 00 7 2 0 0 0
rom_c3      0 f6000 00 7 3 0 0 0
rom_c4      0 f8000 00 7 4 0 0 0
rom_c5      0 fa123 00 7 5 0 0 0
rom_c6      0 fc000 00 7 6 0 0 0
rom_c7      0 fffff 00 7 7 0 0 0
rom_c0      0 f0000 00 0 0 0 0 0
rom_c1      0 f3fff 00 0 0 0 0 0
rom_wr      1 fe000 55 0 0 0 0 0
unmap_lo    0 40000 00 0 0 0 0 0
unmap_hi    1 effff 00 0 0 0 0 0
unmap_mid   0 a0000 00 0 0 0 0 0
page0_wr    3 00080 a5 5 0 0 5 0
page1_wr    3 00081 3c 5 0 1 c 0
page2_wr    3 00082 f7 5 0 2 7 0
page3_wr    3 00083 09 5 0 3 9 0
page_rd80   2 00080 ff 0 0 0 5 0
probe_ch1   0 00000 00 8 0 1 c 0
probe_ch2   0 00000 00 8 0 2 7 0
probe_ch3   0 00000 00 8 0 3 9 0
page0_alias 3 0009c 02 5 0 0 2 0
nmi_on      3 000a0 80 6 0 0 2 1
nmi_rd      2 000a0 00 0 0 1 c 1
nmi_off     3 000a0 7f 6 0 2 7 0
nmi_alias   3 000bf ff 6 0 3 9 1

// ==== tb_pc_bus_glue.sv ====
// ========================================
// reads pc_bus_cases.txt from the project root
// stops at the first error under random back-pressure
// ========================================
`timescale 1ns/10ps
`include "pc_params.svh"

module tb_pc_bus_glue;

   import pc_bus_pkg::*;
   import pc_map_pkg::*;

   localparam int MAX_CASES = 64;

   logic                    clk;
   logic                    reset_n;
   logic                    req_valid_i;
   logic                    req_ready_o;
   cycle_kind_t             req_kind_i;
   logic [`PC_ADDR_W-1:0]   req_addr_i;
   logic [`PC_DATA_W-1:0]   req_wdata_i;
   logic                    res_valid_o;
   logic                    res_ready_i;
   target_t                 res_target_o;
   logic [`PC_UNIT_W-1:0]   res_unit_o;
   cycle_kind_t             res_kind_o;
   logic [1:0]              dma_chan_i;
   logic [`PC_PAGE_W-1:0]   dma_page_o;
   logic                    nmi_enable_o;

   // case table with one entry per data line
   logic [8*16-1:0]         case_name   [MAX_CASES];
   logic [1:0]              case_kind   [MAX_CASES];
   logic [`PC_ADDR_W-1:0]   case_addr   [MAX_CASES];
   logic [`PC_DATA_W-1:0]   case_wdata  [MAX_CASES];
   logic [3:0]              case_target [MAX_CASES];
   logic [`PC_UNIT_W-1:0]   case_unit   [MAX_CASES];
   logic [1:0]              case_chan   [MAX_CASES];
   logic [`PC_PAGE_W-1:0]   case_page   [MAX_CASES];
   logic                    case_nmi    [MAX_CASES];
   int                      num_cases;
   int                      limit;
   int                      cycles;
   int                      exp_q [$];   // accepted cases with the oldest first
   logic [15:0]             lfsr_q;

   pc_bus_glue dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run(input string msg);
      $display("%0s", msg);
      $display("Something failed");
      $fatal(1, "stopping at first error");
   endtask

   // taps x^16 + x^14 + x^13 + x^11 stepped once per bit
   function automatic logic random_bit();
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      return lfsr_q[0];
   endfunction

   task automatic check_target(input logic [8*16-1:0] name, input target_t exp,
                               input target_t act);
      if (act !== exp)
         abort_run($sformatf("ERROR %0s target expected %0d actual %0d", name, exp, act));
   endtask

   task automatic check_kind(input logic [8*16-1:0] name, input cycle_kind_t exp,
                             input cycle_kind_t act);
      if (act !== exp)
         abort_run($sformatf("ERROR %0s kind expected %0d actual %0d", name, exp, act));
   endtask

   task automatic check_unit(input logic [8*16-1:0] name, input logic [`PC_UNIT_W-1:0] exp,
                             input logic [`PC_UNIT_W-1:0] act);
      if (act !== exp)
         abort_run($sformatf("ERROR %0s unit expected %0d actual %0d", name, exp, act));
   endtask

   task automatic check_page(input logic [8*16-1:0] name, input logic [`PC_PAGE_W-1:0] exp,
                             input logic [`PC_PAGE_W-1:0] act);
      if (act !== exp)
         abort_run($sformatf("ERROR %0s page expected %h actual %h", name, exp, act));
   endtask

   task automatic check_nmi(input logic [8*16-1:0] name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("ERROR %0s nmi expected %b actual %b", name, exp, act));
   endtask

   task automatic load_cases();
      int                fd;
      int                n;
      logic [8*120-1:0]  line;
      logic [8*16-1:0]   f_name;
      logic [31:0]       f_kind, f_addr, f_wdata, f_target, f_unit, f_chan, f_page, f_nmi;
      fd = $fopen("pc_bus_cases.txt", "r");
      if (fd == 0)
         abort_run("could not open pc_bus_cases.txt");
      while (!$feof(fd)) begin
         line = '0;
         if ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", f_name, f_kind, f_addr,
                        f_wdata, f_target, f_unit, f_chan, f_page, f_nmi);
            if (n == 9) begin  // comment and blank lines fall out here
               if (num_cases >= MAX_CASES)
                  abort_run("too many test cases in pc_bus_cases.txt");
               case_name[num_cases]   = f_name;
               case_kind[num_cases]   = f_kind[1:0];
               case_addr[num_cases]   = f_addr[`PC_ADDR_W-1:0];
               case_wdata[num_cases]  = f_wdata[`PC_DATA_W-1:0];
               case_target[num_cases] = f_target[3:0];
               case_unit[num_cases]   = f_unit[`PC_UNIT_W-1:0];
               case_chan[num_cases]   = f_chan[1:0];
               case_page[num_cases]   = f_page[`PC_PAGE_W-1:0];
               case_nmi[num_cases]    = f_nmi[0];
               num_cases++;
            end
         end
      end
      $fclose(fd);
      if (num_cases == 0)
         abort_run("no test cases found in pc_bus_cases.txt");
   endtask

   task automatic check_reset_state();
      if (res_valid_o !== 1'b0)
         abort_run("result valid is high right after reset");
      if (req_ready_o !== 1'b1)
         abort_run("request ready is low right after reset");
      for (int ch = 0; ch < `PC_DMA_CHANS; ch++) begin
         dma_chan_i = ch[1:0];
         #1;
         check_page("reset", '0, dma_page_o);
      end
      check_nmi("reset", 1'b0, nmi_enable_o);
   endtask

   initial begin
      cycles = 0;
      wait (limit > 0);
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles >= limit)
            abort_run("timeout, not all results arrived within the cycle limit");
      end
   end

   initial begin
      int   next_case;
      int   done;
      int   idx;
      logic pending;  // request held until accepted
      reset_n     = 1'b0;
      req_valid_i = 1'b0;
      req_kind_i  = mem_read;
      req_addr_i  = '0;
      req_wdata_i = '0;
      res_ready_i = 1'b0;
      dma_chan_i  = '0;
      lfsr_q      = 16'd7;
      num_cases   = 0;
      limit       = 0;
      next_case   = 0;
      done        = 0;
      pending     = 1'b0;
      load_cases();
      limit = 20 * num_cases + 100;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset_n = 1'b1;
      check_reset_state();
      while (done < num_cases) begin
         @(negedge clk);
         res_ready_i = random_bit();
         if (exp_q.size() > 0)
            dma_chan_i = case_chan[exp_q[0]];  // probe for the head result
         if (!pending) begin
            if (next_case < num_cases && random_bit()) begin
               req_kind_i  = cycle_kind_t'(case_kind[next_case]);
               req_addr_i  = case_addr[next_case];
               req_wdata_i = case_wdata[next_case];
               req_valid_i = 1'b1;
               pending     = 1'b1;
            end else begin
               req_valid_i = 1'b0;
            end
         end
         #1;
         // both handshakes below complete on the coming rising edge
         if (res_valid_o && res_ready_i) begin
            if (exp_q.size() == 0)
               abort_run("a result came out with no request outstanding");
            idx = exp_q.pop_front();
            check_target(case_name[idx], target_t'(case_target[idx]), res_target_o);
            check_unit(case_name[idx], case_unit[idx], res_unit_o);
            check_kind(case_name[idx], cycle_kind_t'(case_kind[idx]), res_kind_o);
            check_page(case_name[idx], case_page[idx], dma_page_o);
            check_nmi(case_name[idx], case_nmi[idx], nmi_enable_o);
            done++;
         end
         if (req_valid_i && req_ready_o) begin
            exp_q.push_back(next_case);
            next_case++;
            pending = 1'b0;
         end
      end
      // pipeline must run empty after the last expected result
      repeat (4) begin
         @(negedge clk);
         req_valid_i = 1'b0;
         res_ready_i = 1'b1;
         #1;
         if (res_valid_o)
            abort_run("an extra result came out after the last expected one");
      end
      $display("Everything OK");
      $finish;
   end

endmodule

// ==== pc_bus_glue.sv ====
// ========================================
// PC system board glue, request in and decode out
// 2 cycle latency, writes land as the result is registered
// ========================================
`timescale 1ns/10ps
`include "pc_params.svh"

module pc_bus_glue (
   input  logic                    clk,
   input  logic                    reset_n,
   // request stream
   input  logic                    req_valid_i,
   output logic                    req_ready_o,
   input  pc_bus_pkg::cycle_kind_t req_kind_i,
   input  logic [`PC_ADDR_W-1:0]   req_addr_i,
   input  logic [`PC_DATA_W-1:0]   req_wdata_i,
   // result stream
   output logic                    res_valid_o,
   input  logic                    res_ready_i,
   output pc_map_pkg::target_t     res_target_o,
   output logic [`PC_UNIT_W-1:0]   res_unit_o,
   output pc_bus_pkg::cycle_kind_t res_kind_o,
   // DMA page lookup
   input  logic [1:0]              dma_chan_i,
   output logic [`PC_PAGE_W-1:0]   dma_page_o,
   output logic                    nmi_enable_o
);

   import pc_bus_pkg::*;
   import pc_map_pkg::*;

   bus_cycle_t            req_data;
   bus_cycle_t            cyc_q;     // cycle being decoded
   logic                  cyc_valid;
   logic                  cyc_ready;
   target_t               io_target;
   target_t               mem_target;
   logic [`PC_UNIT_W-1:0] mem_unit;
   decode_result_t        res_d;
   decode_result_t        res_q;
   logic                  cyc_move;

   assign req_data = '{kind: req_kind_i, addr: req_addr_i, wdata: req_wdata_i};

   stream_stage #(
      .payload_t(bus_cycle_t)
   ) in_stage (
      .clk         (clk),
      .reset_n     (reset_n),
      .in_valid_i  (req_valid_i),
      .in_ready_o  (req_ready_o),
      .in_data_i   (req_data),
      .out_valid_o (cyc_valid),
      .out_ready_i (cyc_ready),
      .out_data_o  (cyc_q)
   );

   port_decoder u_port_dec (
      .kind_i   (cyc_q.kind),
      .port_i   (cyc_q.addr[`PC_PORT_W-1:0]),  // A19..A10 ignored
      .target_o (io_target)
   );

   mem_decoder u_mem_dec (
      .kind_i   (cyc_q.kind),
      .addr_i   (cyc_q.addr),
      .target_o (mem_target),
      .unit_o   (mem_unit)
   );

   // only one decoder answers for a given kind
   // mem_decoder returns unit 0 for I/O cycles
   assign res_d = '{
      target: (io_target != none) ? io_target : mem_target,
      unit:   mem_unit,
      kind:   cyc_q.kind
   };

   stream_stage #(
      .payload_t(decode_result_t)
   ) out_stage (
      .clk         (clk),
      .reset_n     (reset_n),
      .in_valid_i  (cyc_valid),
      .in_ready_o  (cyc_ready),
      .in_data_i   (res_d),
      .out_valid_o (res_valid_o),
      .out_ready_i (res_ready_i),
      .out_data_o  (res_q)
   );

   // one write per cycle, on its hand-over to out_stage
   assign cyc_move = cyc_valid && cyc_ready;

   board_registers u_regs (
      .clk          (clk),
      .reset_n      (reset_n),
      .wr_en_i      (cyc_move),
      .target_i     (res_d.target),
      .index_i      (cyc_q.addr[1:0]),
      .wdata_i      (cyc_q.wdata),
      .dma_chan_i   (dma_chan_i),
      .dma_page_o   (dma_page_o),
      .nmi_enable_o (nmi_enable_o)
   );

   assign res_target_o = res_q.target;
   assign res_unit_o   = res_q.unit;
   assign res_kind_o   = res_q.kind;

endmodule

// ==== board_registers.sv ====
// ========================================
// DMA page registers (LS670) and NMI mask bit
// write on wr_en_i, page read is combinational
// ========================================
`timescale 1ns/10ps
`include "pc_params.svh"

module board_registers (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   wr_en_i,
   input  pc_map_pkg::target_t    target_i,
   input  logic [1:0]             index_i,
   input  logic [`PC_DATA_W-1:0]  wdata_i,
   input  logic [1:0]             dma_chan_i,
   output logic [`PC_PAGE_W-1:0]  dma_page_o,
   output logic                   nmi_enable_o
);

   import pc_map_pkg::*;

   logic [`PC_PAGE_W-1:0] page_q [`PC_DMA_CHANS];
   logic                  nmi_q;
   logic                  page_wr;
   logic                  nmi_wr;

   assign page_wr = wr_en_i && (target_i == dma_page);
   assign nmi_wr  = wr_en_i && (target_i == nmi_mask);

   // write port, WA/WB from XA0/XA1
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         page_q <= '{default: '0};
      end else if (page_wr) begin
         page_q[index_i] <= wdata_i[`PC_PAGE_W-1:0];
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         nmi_q <= 1'b0;  // NMI off until software enables it
      end else if (nmi_wr) begin
         nmi_q <= wdata_i[`PC_NMI_BIT];
      end
   end

   // read port, independent of writes
   assign dma_page_o   = page_q[dma_chan_i];
   assign nmi_enable_o = nmi_q;

   a_known_wdata: assert property (
      @(posedge clk) disable iff (!reset_n)
      wr_en_i && is_board_reg(target_i) |-> !$isunknown(wdata_i)
   ) else $error("register write with unknown data");

endmodule

// ==== mem_decoder.sv ====
// ========================================
// memory map: 256K RAM at 00000, ROM in segment F
// chips 0 and 1 of the ROM space are empty sockets
// ========================================
`timescale 1ns/10ps
`include "pc_params.svh"

module mem_decoder (
   input  pc_bus_pkg::cycle_kind_t kind_i,
   input  logic [`PC_ADDR_W-1:0]   addr_i,
   output pc_map_pkg::target_t     target_o,
   output logic [`PC_UNIT_W-1:0]   unit_o
);

   import pc_bus_pkg::*;
   import pc_map_pkg::*;

   logic                 is_mem;
   logic                 ram_sel;
   logic                 rom_sel;
   logic [1:0]           bank;
   logic [`PC_UNIT_W-1:0] chip;
   logic                 chip_fitted;

   assign is_mem  = !is_io_kind(kind_i);
   assign ram_sel = (addr_i[19:18] == `PC_RAM_SEG);  // RAM ADDR SEL
   assign rom_sel = (addr_i[19:16] == `PC_ROM_SEG);  // ROM ADDR SEL
   assign bank    = addr_i[17:16];                   // RAS/CAS select
   assign chip    = addr_i[15:13];                   // 8K per chip

   assign chip_fitted = (chip >= `PC_UNIT_W'(`PC_ROM_FIRST_CHIP));

   always_comb begin
      target_o = none;
      unit_o   = '0;
      if (is_mem) begin
         if (ram_sel) begin
            target_o = ram;
            unit_o   = {1'b0, bank};
         end else if (rom_sel && !is_write_kind(kind_i) && chip_fitted) begin
            target_o = rom;  // CS gated by XMEMR, writes fall through
            unit_o   = chip;
         end
      end
   end

   always_comb begin
      a_ram_bank_range: assert final (target_o != ram || unit_o < `PC_RAM_BANKS)
         else $error("RAM bank %0d out of range", unit_o);
   end

endmodule

// ==== port_decoder.sv ====
// ========================================
// I/O select of sheet 3 (the LS138 on XA9..XA5)
// AEN is not modelled, DMA cycles never reach here
// ========================================
`timescale 1ns/10ps
`include "pc_params.svh"

module port_decoder (
   input  pc_bus_pkg::cycle_kind_t kind_i,
   input  logic [`PC_PORT_W-1:0]   port_i,
   output pc_map_pkg::target_t     target_o
);

   import pc_bus_pkg::*;
   import pc_map_pkg::*;

   logic       sel_en;
   logic       is_wr;
   logic [2:0] group;

   // G2A/G2B tied to XA9 and XA8
   assign sel_en = is_io_kind(kind_i) && (port_i[9:8] == 2'b00);
   assign is_wr  = is_write_kind(kind_i);
   assign group  = port_i[7:5];

   always_comb begin
      target_o = none;
      if (sel_en) begin
         case (group)
            `PC_GRP_DMA:   target_o = dma_ctrl;
            `PC_GRP_INT:   target_o = int_ctrl;
            `PC_GRP_TIMER: target_o = timer;
            `PC_GRP_PPI:   target_o = periph;
            // these two outputs are gated with XIOW on the board
            `PC_GRP_PAGE:  target_o = is_wr ? dma_page : none;
            `PC_GRP_NMI:   target_o = is_wr ? nmi_mask : none;
            default:       target_o = none;  // groups 6 and 7 unused
         endcase
      end
   end

   always_comb begin
      a_no_io_on_mem: assert final (is_io_kind(kind_i) || !is_io_target(target_o))
         else $error("I/O target decoded for a memory cycle");
   end

endmodule

// ==== stream_stage.sv ====
// ========================================
// single valid/ready register slice
// full throughput, ready depends on downstream ready
// ========================================
`timescale 1ns/10ps

module stream_stage #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk,
   input  logic     reset_n,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   input  payload_t in_data_i,
   output logic     out_valid_o,
   input  logic     out_ready_i,
   output payload_t out_data_o
);

   logic     full_q;
   payload_t data_q;
   logic     load;

   // empty, or the held word leaves this cycle
   assign in_ready_o = !full_q || out_ready_i;
   assign load       = in_valid_i && in_ready_o;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         full_q <= 1'b0;
      end else if (in_ready_o) begin
         full_q <= in_valid_i;  // drain, refill or go empty
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         data_q <= in_data_i;
      end
   end

   assign out_valid_o = full_q;
   assign out_data_o  = data_q;

   // a stalled word must stay put until taken
   a_hold_on_stall: assert property (
      @(posedge clk) disable iff (!reset_n)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
   ) else $error("stream_stage dropped or changed a stalled word");

endmodule

// ==== pc_map_pkg.sv ====
// ========================================
// decode targets and the result word
// one target per cycle, none when nothing on the board answers
// ========================================
`include "pc_params.svh"

package pc_map_pkg;

   typedef enum logic [3:0] {
      none     = 4'd0,
      dma_ctrl = 4'd1,  // 8237
      int_ctrl = 4'd2,  // 8259
      timer    = 4'd3,  // 8253
      periph   = 4'd4,  // 8255
      dma_page = 4'd5,  // LS670 write strobe
      nmi_mask = 4'd6,  // NMI mask flip-flop
      rom      = 4'd7,
      ram      = 4'd8
   } target_t;

   // result payload, 9 bits
   typedef struct packed {
      target_t                 target;
      logic [`PC_UNIT_W-1:0]   unit;   // ROM chip or RAM bank, else 0
      pc_bus_pkg::cycle_kind_t kind;   // echoed from the request
   } decode_result_t;

   // targets reached through the port decoder
   function automatic logic is_io_target(target_t target);
      return (target != none) && (target != rom) && (target != ram);
   endfunction

   // targets that hold state on this board
   function automatic logic is_board_reg(target_t target);
      return (target == dma_page) || (target == nmi_mask);
   endfunction

endpackage

// ==== pc_bus_pkg.sv ====
// ========================================
// bus cycle request types
// kind, address and write data travel as one word
// ========================================
`include "pc_params.svh"

package pc_bus_pkg;

   // order follows the 8288 command decode loosely
   typedef enum logic [1:0] {
      mem_read  = 2'd0,
      mem_write = 2'd1,
      io_read   = 2'd2,
      io_write  = 2'd3
   } cycle_kind_t;

   // request payload, 30 bits
   typedef struct packed {
      cycle_kind_t             kind;
      logic [`PC_ADDR_W-1:0]   addr;
      logic [`PC_DATA_W-1:0]   wdata;  // don't care on reads
   } bus_cycle_t;

   // IOR/IOW as opposed to MEMR/MEMW
   function automatic logic is_io_kind(cycle_kind_t kind);
      return (kind == io_read) || (kind == io_write);
   endfunction

   function automatic logic is_write_kind(cycle_kind_t kind);
      return (kind == mem_write) || (kind == io_write);
   endfunction

endpackage

// ==== pc_params.svh ====
// ========================================
// widths and map constants of the PC board glue
// I/O decode sees only 10 address bits, as on the real board
// ========================================
`ifndef PC_PARAMS_SVH
`define PC_PARAMS_SVH

// bus and data widths
`define PC_ADDR_W         20
`define PC_DATA_W         8
`define PC_PORT_W         10  // XA9..XA0
`define PC_PAGE_W         4   // LS670 word width
`define PC_DMA_CHANS      4
`define PC_UNIT_W         3

// I/O port groups on XA7..XA5
`define PC_GRP_DMA        3'd0  // 8237, ports 00-1F
`define PC_GRP_INT        3'd1  // 8259, ports 20-3F
`define PC_GRP_TIMER      3'd2  // 8253, ports 40-5F
`define PC_GRP_PPI        3'd3  // 8255, ports 60-7F
`define PC_GRP_PAGE       3'd4  // page register, write only
`define PC_GRP_NMI        3'd5  // NMI mask, write only

// memory map
`define PC_RAM_SEG        2'b00 // A19..A18 for system board RAM
`define PC_ROM_SEG        4'hF  // A19..A16 for the ROM space
`define PC_ROM_FIRST_CHIP 2
`define PC_RAM_BANKS      4
`define PC_NMI_BIT        7

`endif
